// ==== list.f ====
verilog/csa_pkg.sv
verilog/cw_ctrl_reg.sv
verilog/ts_pkt_buffer.sv
verilog/ts_readout.sv
verilog/frame_out_mux.sv
verilog/csa_frame_top.sv
tests/csa_frame_assert.sv
tests/csa_frame_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the csa_frame testbench with Verilator.
# The exit status is the simulator's own status.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	-f list.f --top-module csa_frame_tb -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit $status
fi

./obj_dir/Vcsa_frame_tb
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi
exit 0

// ==== tests/csa_frame_assert.sv ====
module csa_frame_assert
(
	input logic clk,
	input logic rst,
	input logic out_valid,
	input logic finish_pkt
);

	// end-of-packet is a single-cycle pulse
	finish_single: assert property (@(posedge clk) disable iff (rst)
		finish_pkt |=> !finish_pkt)
		else $error("finish_pkt stayed high for two cycles");

	// last packet byte leaves just before the pulse
	finish_after_data: assert property (@(posedge clk) disable iff (rst)
		finish_pkt |-> ($past(out_valid) || $past(out_valid, 2)))
		else $error("finish_pkt pulsed with no out_valid in the two cycles before");

	// outputs quiet right after reset
	reset_quiet: assert property (@(posedge clk)
		rst |=> (!out_valid && !finish_pkt))
		else $error("out_valid or finish_pkt high in the cycle after reset");

endmodule

bind csa_frame_top csa_frame_assert csa_frame_assert_inst
(
	.clk(clk),
	.rst(rst),
	.out_valid(out_valid),
	.finish_pkt(finish_pkt)
);

// ==== tests/csa_frame_tb.sv ====
module csa_frame_tb;

	localparam int PKT = csa_pkg::PKT_BYTES;
	localparam int CW = csa_pkg::CW_BYTES;
	localparam int CLK_PERIOD = 4;
	localparam int RESET_CYCLES = 8;
	localparam int NUM_TESTS = 6;
	localparam int WD_CYCLES = RESET_CYCLES + NUM_TESTS * (2 * PKT + 64);

	logic clk;
	logic rst;
	logic ts_valid;
	csa_pkg::byte_t ts_byte;
	logic cw_valid;
	csa_pkg::byte_t cw_byte;
	logic cnt_valid;
	csa_pkg::byte_t cnt_byte;
	logic pid_valid;
	csa_pkg::byte_t pid_byte;
	logic gbe_valid;
	csa_pkg::byte_t gbe_byte;
	logic port_valid;
	csa_pkg::byte_t port_byte;
	logic out_valid;
	csa_pkg::byte_t out_byte;
	logic finish_pkt;

	// collected output stream
	csa_pkg::byte_t got_q [$];
	csa_pkg::byte_t pkt_data [PKT];
	// count, pid, gbe, port
	csa_pkg::byte_t hdr_val [4];
	// head byte of the last control word record
	csa_pkg::byte_t cur_cw0;

	csa_frame_top #(.PKT_BYTES(PKT), .CW_BYTES(CW)) csa_frame_top_inst
	(
		.clk(clk),
		.rst(rst),
		.ts_valid(ts_valid),
		.ts_byte(ts_byte),
		.cw_valid(cw_valid),
		.cw_byte(cw_byte),
		.cnt_valid(cnt_valid),
		.cnt_byte(cnt_byte),
		.pid_valid(pid_valid),
		.pid_byte(pid_byte),
		.gbe_valid(gbe_valid),
		.gbe_byte(gbe_byte),
		.port_valid(port_valid),
		.port_byte(port_byte),
		.out_valid(out_valid),
		.out_byte(out_byte),
		.finish_pkt(finish_pkt)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	always @(posedge clk)
	begin
		if (out_valid)
			got_q.push_back(out_byte);
	end

	////////////////////////////////////////////////////////////
	// reporting and compare helpers
	////////////////////////////////////////////////////////////

	task automatic report_fail(input string line);
		$display("%s", line);
		$display("Result: FAILED");
		$fatal(1, "stopping on first error");
	endtask

	task automatic check_byte(input string name, input csa_pkg::byte_t got,
		input csa_pkg::byte_t exp);
		if (got !== exp)
			report_fail($sformatf("FAILED %s: got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic check_pulse(input string name, input logic got, input logic exp);
		if (got !== exp)
			report_fail($sformatf("FAILED %s: got 0x%h expected 0x%h", name, got, exp));
	endtask

	function automatic csa_pkg::byte_t rand_byte();
		logic [31:0] r;
		r = $urandom();
		return r[7:0];
	endfunction

	// header byte 3 takes {bit1, bit1 & bit0} of the cw head when bit1 is set
	function automatic csa_pkg::byte_t expect_pkt_byte(input int idx,
		input csa_pkg::byte_t in_b, input csa_pkg::byte_t cw0);
		csa_pkg::ts_hdr3_u h;
		h.raw = in_b;
		if (idx == csa_pkg::SCRAMBLE_HDR_IDX && cw0[1])
			h.f.sc = {cw0[1], cw0[1] & cw0[0]};
		return h.raw;
	endfunction

	task automatic wait_bytes(input int n, input int limit);
		int cycles;
		cycles = 0;
		while (got_q.size() < n)
		begin
			if (cycles == limit)
				report_fail($sformatf("only %0d of %0d expected output bytes arrived",
					got_q.size(), n));
			cycles++;
			@(negedge clk);
		end
	endtask

	// a few idle cycles, then the byte count must be exact
	task automatic settle_and_count(input int n);
		repeat (3) @(negedge clk);
		if (got_q.size() != n)
			report_fail($sformatf("expected %0d output bytes but collected %0d",
				n, got_q.size()));
	endtask

	// pulse lands one cycle after the last byte and lasts one cycle
	task automatic wait_finish(input int limit);
		int cycles;
		logic prev_ov;
		cycles = 0;
		prev_ov = 1'b0;
		@(negedge clk);
		while (finish_pkt !== 1'b1)
		begin
			if (cycles == limit)
				report_fail("finish_pkt never pulsed after the packet was sent");
			cycles++;
			prev_ov = out_valid;
			@(negedge clk);
		end
		check_pulse("out_valid before finish_pkt", prev_ov, 1'b1);
		@(negedge clk);
		check_pulse("finish_pkt", finish_pkt, 1'b0);
	endtask

	////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////

	// sel bits select count, pid, gbe, port
	task automatic strobe_hdr(input logic [3:0] sel);
		@(posedge clk);
		cnt_valid <= sel[0];
		cnt_byte <= hdr_val[0];
		pid_valid <= sel[1];
		pid_byte <= hdr_val[1];
		gbe_valid <= sel[2];
		gbe_byte <= hdr_val[2];
		port_valid <= sel[3];
		port_byte <= hdr_val[3];
		@(posedge clk);
		cnt_valid <= 1'b0;
		pid_valid <= 1'b0;
		gbe_valid <= 1'b0;
		port_valid <= 1'b0;
	endtask

	task automatic load_cw(input csa_pkg::byte_t cw0);
		csa_pkg::byte_t cw_data [CW];
		@(negedge clk);
		got_q.delete();
		cw_data[0] = cw0;
		for (int i = 1; i < CW; i++)
			cw_data[i] = rand_byte();
		for (int i = 0; i < CW; i++)
		begin
			@(posedge clk);
			cw_valid <= 1'b1;
			cw_byte <= cw_data[i];
		end
		@(posedge clk);
		cw_valid <= 1'b0;
		wait_bytes(CW, 16);
		settle_and_count(CW);
		// record head shrinks to the scramble flag
		check_byte("out_byte[cw 0]", got_q[0], {7'b0, cw0[1]});
		for (int i = 1; i < CW; i++)
			check_byte($sformatf("out_byte[cw %0d]", i), got_q[i], cw_data[i]);
		cur_cw0 = cw0;
	endtask

	task automatic run_packet();
		@(negedge clk);
		got_q.delete();
		for (int i = 0; i < PKT; i++)
			pkt_data[i] = rand_byte();
		// top bit of byte 3 opposite to any rewrite, so a wrong rewrite shows
		pkt_data[csa_pkg::SCRAMBLE_HDR_IDX][7] = ~cur_cw0[1];
		for (int i = 0; i < PKT; i++)
		begin
			@(posedge clk);
			ts_valid <= 1'b1;
			ts_byte <= pkt_data[i];
		end
		@(posedge clk);
		ts_valid <= 1'b0;
		wait_finish(PKT + 32);
		settle_and_count(PKT);
		for (int i = 0; i < PKT; i++)
			check_byte($sformatf("out_byte[pkt %0d]", i), got_q[i],
				expect_pkt_byte(i, pkt_data[i], cur_cw0));
	endtask

	////////////////////////////////////////////////////////////
	// directed tests
	////////////////////////////////////////////////////////////

	task automatic test_reset_quiet();
		repeat (16)
		begin
			@(negedge clk);
			check_pulse("out_valid", out_valid, 1'b0);
			check_pulse("finish_pkt", finish_pkt, 1'b0);
		end
	endtask

	task automatic test_header_bytes();
		for (int k = 0; k < 4; k++)
		begin
			@(negedge clk);
			got_q.delete();
			for (int j = 0; j < 4; j++)
				hdr_val[j] = rand_byte();
			strobe_hdr(4'b0001 << k);
			wait_bytes(1, 8);
			settle_and_count(1);
			check_byte($sformatf("out_byte[hdr %0d]", k), got_q[0], hdr_val[k]);
		end
		// all four at once, count wins
		@(negedge clk);
		got_q.delete();
		for (int j = 0; j < 4; j++)
			hdr_val[j] = rand_byte();
		strobe_hdr(4'b1111);
		wait_bytes(1, 8);
		settle_and_count(1);
		check_byte("out_byte[hdr all]", got_q[0], hdr_val[0]);
	endtask

	task automatic test_control_word();
		load_cw(rand_byte());
	endtask

	task automatic test_clear_packet();
		load_cw(rand_byte() & 8'hfd);
		run_packet();
	endtask

	task automatic test_scrambled_packet();
		load_cw((rand_byte() & 8'h01) | 8'h02);
		run_packet();
	endtask

	task automatic test_two_packets();
		run_packet();
		run_packet();
	endtask

	initial
	begin
		clk = 1'b0;
		rst = 1'b1;
		ts_valid = 1'b0;
		ts_byte = '0;
		cw_valid = 1'b0;
		cw_byte = '0;
		cnt_valid = 1'b0;
		cnt_byte = '0;
		pid_valid = 1'b0;
		pid_byte = '0;
		gbe_valid = 1'b0;
		gbe_byte = '0;
		port_valid = 1'b0;
		port_byte = '0;
		cur_cw0 = '0;
		void'($urandom(74));
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
		test_reset_quiet();
		test_header_bytes();
		test_control_word();
		test_clear_packet();
		test_scrambled_packet();
		test_two_packets();
		$display("Result: PASSED");
		$finish;
	end

	initial
	begin
		#(WD_CYCLES * CLK_PERIOD);
		report_fail("watchdog expired before the tests finished");
	end

endmodule

// ==== verilog/csa_frame_top.sv ====
module csa_frame_top
#(
	parameter int PKT_BYTES = csa_pkg::PKT_BYTES,
	parameter int CW_BYTES = csa_pkg::CW_BYTES
)
(
	input logic clk,
	input logic rst,
	input logic ts_valid,
	input csa_pkg::byte_t ts_byte,
	input logic cw_valid,
	input csa_pkg::byte_t cw_byte,
	input logic cnt_valid,
	input csa_pkg::byte_t cnt_byte,
	input logic pid_valid,
	input csa_pkg::byte_t pid_byte,
	input logic gbe_valid,
	input csa_pkg::byte_t gbe_byte,
	input logic port_valid,
	input csa_pkg::byte_t port_byte,
	output logic out_valid,
	output csa_pkg::byte_t out_byte,
	output logic finish_pkt
);

	// buffer <-> readout
	logic pkt_full;
	logic busy;
	logic rd_en;
	logic [$clog2(PKT_BYTES)-1:0] rd_addr;
	csa_pkg::byte_t rd_data;

	// readout -> mux
	logic pkt_valid;
	csa_pkg::byte_t pkt_byte;

	// control word side
	logic cw_first;
	csa_pkg::scram_ctrl_t scram_ctrl;

	cw_ctrl_reg #(.CW_BYTES(CW_BYTES)) cw_ctrl_reg_inst
	(
		.clk(clk),
		.rst(rst),
		.cw_valid(cw_valid),
		.cw_byte(cw_byte),
		.cw_first(cw_first),
		.scram_ctrl(scram_ctrl)
	);

	ts_pkt_buffer #(.PKT_BYTES(PKT_BYTES)) ts_pkt_buffer_inst
	(
		.clk(clk),
		.rst(rst),
		.ts_valid(ts_valid),
		.ts_byte(ts_byte),
		.busy(busy),
		.rd_en(rd_en),
		.rd_addr(rd_addr),
		.pkt_full(pkt_full),
		.rd_data(rd_data)
	);

	ts_readout #(.PKT_BYTES(PKT_BYTES)) ts_readout_inst
	(
		.clk(clk),
		.rst(rst),
		.pkt_full(pkt_full),
		.rd_data(rd_data),
		.scram_ctrl(scram_ctrl),
		.rd_en(rd_en),
		.rd_addr(rd_addr),
		.busy(busy),
		.pkt_valid(pkt_valid),
		.pkt_byte(pkt_byte),
		.finish_pkt(finish_pkt)
	);

	frame_out_mux frame_out_mux_inst
	(
		.clk(clk),
		.rst(rst),
		.pkt_valid(pkt_valid),
		.pkt_byte(pkt_byte),
		.cnt_valid(cnt_valid),
		.cnt_byte(cnt_byte),
		.pid_valid(pid_valid),
		.pid_byte(pid_byte),
		.gbe_valid(gbe_valid),
		.gbe_byte(gbe_byte),
		.port_valid(port_valid),
		.port_byte(port_byte),
		.cw_valid(cw_valid),
		.cw_byte(cw_byte),
		.cw_first(cw_first),
		.out_valid(out_valid),
		.out_byte(out_byte)
	);

endmodule

// ==== verilog/csa_pkg.sv ====
package csa_pkg;

	////////////////////////////////////////////////////////////
	// stream sizes
	////////////////////////////////////////////////////////////

	// one TS packet
	localparam int PKT_BYTES = 188;

	// scramble flag byte plus an 8-byte control word
	localparam int CW_BYTES = 9;

	// header byte carrying the scrambling-control bits
	localparam int SCRAMBLE_HDR_IDX = 3;

	////////////////////////////////////////////////////////////
	// types
	////////////////////////////////////////////////////////////

	typedef logic [7:0] byte_t;

	// transport_scrambling_control field
	typedef logic [1:0] scram_ctrl_t;

	// header byte 3, seen either as a plain byte or split into its fields
	typedef union packed
	{
		byte_t raw;
		struct packed
		{
			scram_ctrl_t sc;
			logic [1:0] afc;
			logic [3:0] cc;
		} f;
	} ts_hdr3_u;

endpackage

// ==== verilog/cw_ctrl_reg.sv ====
module cw_ctrl_reg
#(
	parameter int CW_BYTES = csa_pkg::CW_BYTES
)
(
	input logic clk,
	input logic rst,
	input logic cw_valid,
	input csa_pkg::byte_t cw_byte,
	output logic cw_first,
	output csa_pkg::scram_ctrl_t scram_ctrl
);

	localparam int CW_AW = $clog2(CW_BYTES);

	// position of the next cw byte inside its record
	logic [CW_AW-1:0] cw_idx;

	assign cw_first = cw_valid && (cw_idx == '0);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			cw_idx <= '0;
		end
		else if (cw_valid)
		begin
			if (cw_idx == CW_AW'(CW_BYTES - 1))
				cw_idx <= '0;
			else
				cw_idx <= cw_idx + 1'b1;
		end
	end

	// first record byte carries the scramble enable in bit 1
	always_ff @(posedge clk)
	begin
		if (rst)
			scram_ctrl <= '0;
		else if (cw_first)
			scram_ctrl <= {cw_byte[1], cw_byte[1] & cw_byte[0]};
	end

endmodule

// ==== verilog/frame_out_mux.sv ====
module frame_out_mux
(
	input logic clk,
	input logic rst,
	input logic pkt_valid,
	input csa_pkg::byte_t pkt_byte,
	input logic cnt_valid,
	input csa_pkg::byte_t cnt_byte,
	input logic pid_valid,
	input csa_pkg::byte_t pid_byte,
	input logic gbe_valid,
	input csa_pkg::byte_t gbe_byte,
	input logic port_valid,
	input csa_pkg::byte_t port_byte,
	input logic cw_valid,
	input csa_pkg::byte_t cw_byte,
	input logic cw_first,
	output logic out_valid,
	output csa_pkg::byte_t out_byte
);

	logic any_valid;
	csa_pkg::byte_t sel_byte;
	csa_pkg::byte_t cw_out;

	// record head collapses to the scramble flag alone
	assign cw_out = cw_first ? {7'b0, cw_byte[1]} : cw_byte;

	assign any_valid = pkt_valid | cnt_valid | pid_valid | gbe_valid | port_valid
		| cw_valid;

	////////////////////////////////////////////////////////////
	// packet first, then the frame header fields, cw last
	////////////////////////////////////////////////////////////

	always_comb
	begin
		if (pkt_valid)
			sel_byte = pkt_byte;
		else if (cnt_valid)
			sel_byte = cnt_byte;
		else if (pid_valid)
			sel_byte = pid_byte;
		else if (gbe_valid)
			sel_byte = gbe_byte;
		else if (port_valid)
			sel_byte = port_byte;
		else
			sel_byte = cw_out;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			out_valid <= 1'b0;
			out_byte <= '0;
		end
		else
		begin
			out_valid <= any_valid;
			// keep the last byte when idle
			if (any_valid)
				out_byte <= sel_byte;
		end
	end

endmodule

// ==== verilog/ts_pkt_buffer.sv ====
module ts_pkt_buffer
#(
	parameter int PKT_BYTES = csa_pkg::PKT_BYTES
)
(
	input logic clk,
	input logic rst,
	input logic ts_valid,
	input csa_pkg::byte_t ts_byte,
	input logic busy,
	input logic rd_en,
	input logic [$clog2(PKT_BYTES)-1:0] rd_addr,
	output logic pkt_full,
	output csa_pkg::byte_t rd_data
);

	localparam int AW = $clog2(PKT_BYTES);

	csa_pkg::byte_t mem [PKT_BYTES];

	// counts every ts strobe, busy or not
	logic [AW-1:0] wr_idx;
	logic wr_last;

	assign wr_last = ts_valid && (wr_idx == AW'(PKT_BYTES - 1));

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wr_idx <= '0;
			pkt_full <= 1'b0;
		end
		else
		begin
			if (ts_valid)
				wr_idx <= wr_last ? '0 : wr_idx + 1'b1;
			pkt_full <= wr_last && !busy;
		end
	end

	////////////////////////////////////////////////////////////
	// storage
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (ts_valid && !busy)
			mem[wr_idx] <= ts_byte;
		if (rd_en)
			rd_data <= mem[rd_addr];
	end

endmodule

// ==== verilog/ts_readout.sv ====
module ts_readout
#(
	parameter int PKT_BYTES = csa_pkg::PKT_BYTES
)
(
	input logic clk,
	input logic rst,
	input logic pkt_full,
	input csa_pkg::byte_t rd_data,
	input csa_pkg::scram_ctrl_t scram_ctrl,
	output logic rd_en,
	output logic [$clog2(PKT_BYTES)-1:0] rd_addr,
	output logic busy,
	output logic pkt_valid,
	output csa_pkg::byte_t pkt_byte,
	output logic finish_pkt
);

	localparam int AW = $clog2(PKT_BYTES);

	// read phase of the sequencer; idle otherwise
	logic reading;
	// rd_data valid this cycle
	logic rd_vld_d1;
	// index of the byte now on rd_data
	logic [AW-1:0] ret_idx;
	logic ret_last;
	logic [1:0] end_pipe;
	csa_pkg::ts_hdr3_u hdr;

	assign rd_en = reading;
	assign ret_last = rd_vld_d1 && (ret_idx == AW'(PKT_BYTES - 1));

	////////////////////////////////////////////////////////////
	// sequencer
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			reading <= 1'b0;
			rd_addr <= '0;
			busy <= 1'b0;
			rd_vld_d1 <= 1'b0;
			ret_idx <= '0;
			end_pipe <= '0;
			finish_pkt <= 1'b0;
		end
		else
		begin
			if (pkt_full && !busy)
			begin
				reading <= 1'b1;
				busy <= 1'b1;
				rd_addr <= '0;
				ret_idx <= '0;
			end
			else
			begin
				if (reading)
				begin
					rd_addr <= rd_addr + 1'b1;
					if (rd_addr == AW'(PKT_BYTES - 1))
						reading <= 1'b0;
				end
				if (rd_vld_d1)
					ret_idx <= ret_idx + 1'b1;
				// release once the last byte has left the mux
				if (end_pipe[1])
					busy <= 1'b0;
			end
			rd_vld_d1 <= rd_en;
			end_pipe <= {end_pipe[0], ret_last};
			finish_pkt <= end_pipe[1];
		end
	end

	// byte 3 gets the new scrambling-control bits, rest passes
	always_comb
	begin
		hdr.raw = rd_data;
		if (ret_idx == AW'(csa_pkg::SCRAMBLE_HDR_IDX) && scram_ctrl[1])
			hdr.f.sc = scram_ctrl;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			pkt_valid <= 1'b0;
		else
			pkt_valid <= rd_vld_d1;
	end

	always_ff @(posedge clk)
	begin
		if (rd_vld_d1)
			pkt_byte <= hdr.raw;
	end

endmodule
